// File: verilog/buf_types_pkg.sv
package buf_types_pkg;

// Byte lanes per packed word.
localparam int BYTES_PER_WORD = 4;
localparam int LANE_IDX_W     = 2;   // Enough to count BYTES_PER_WORD lanes.

// One byte of the stream.
typedef logic [7:0] byte_t;

// Four bytes, lane 0 in the low byte.
typedef logic [BYTES_PER_WORD*8-1:0] word_t;

endpackage

// File: verilog/buf_cfg_pkg.sv
package buf_cfg_pkg;

// Depth is kept a power of two by deriving it from the pointer width.
localparam int FIFO_PTR_W = 4;
localparam int FIFO_DEPTH = 2 ** FIFO_PTR_W;

// 1 selects wrap-bit status, 0 the occupancy counter.
localparam int FIFO_STATUS_MODE = 1;

endpackage

// File: verilog/bram.sv
`timescale 1ns/1ps

module bram #(
    parameter int MEM_WIDTH = 32,
    parameter int MEM_DEPTH = 16
) (
    input  logic                         clk_i,
    input  logic                         wr_en_i,
    input  logic [$clog2(MEM_DEPTH)-1:0] wr_addr_i,
    input  logic [MEM_WIDTH-1:0]         wr_data_i,
    input  logic                         rd_en_i,
    input  logic [$clog2(MEM_DEPTH)-1:0] rd_addr_i,
    output logic [MEM_WIDTH-1:0]         rd_data_o
);

logic [MEM_WIDTH-1:0] mem [MEM_DEPTH];

always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
        mem[wr_addr_i] <= wr_data_i;
    end
end

// Registered read, output holds when not enabled.
always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
        rd_data_o <= mem[rd_addr_i];
    end
end

endmodule

// File: verilog/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter int FIFO_WIDTH = 32,
    parameter int FIFO_DEPTH = 16,
    parameter int CIRCLE_BUF = 1
) (
    input  logic                  clk_i,
    input  logic                  arstn_i,

    input  logic [FIFO_WIDTH-1:0] data_i,
    input  logic                  push_i,
    input  logic                  pop_i,

    output logic [FIFO_WIDTH-1:0] data_o,
    output logic                  full_o,
    output logic                  empty_o
);

localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);
localparam logic [PTR_WIDTH-1:0] MAX_PTR = PTR_WIDTH'(FIFO_DEPTH - 1);

logic [PTR_WIDTH-1:0]  wr_ptr;
logic [PTR_WIDTH-1:0]  rd_ptr;
logic [PTR_WIDTH-1:0]  rd_next_ptr;   // Address of the word behind the head.
logic                  last_word;     // Exactly one word stored.
logic                  ram_we;
logic                  ram_re;
logic [FIFO_WIDTH-1:0] ram_q;
logic [FIFO_WIDTH-1:0] byp_data;
logic                  byp_valid;
logic                  byp_load;
logic                  wr_wrap;
logic                  rd_wrap;

assign wr_wrap = (wr_ptr == MAX_PTR);
assign rd_wrap = (rd_ptr == MAX_PTR);

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
        wr_ptr <= '0;
    end else if (push_i) begin
        wr_ptr <= wr_wrap ? '0 : wr_ptr + 1'b1;
    end
end

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
        rd_ptr <= '0;
    end else if (pop_i) begin
        rd_ptr <= rd_wrap ? '0 : rd_ptr + 1'b1;
    end
end

assign rd_next_ptr = rd_wrap ? '0 : rd_ptr + 1'b1;
assign last_word   = (wr_ptr == rd_next_ptr);

// A word that becomes the head right away skips the RAM.
assign byp_load = push_i & (empty_o | (pop_i & last_word));
assign ram_we   = push_i & ~byp_load;
assign ram_re   = pop_i & ~last_word;   // Prefetch the next head.

always_ff @(posedge clk_i) begin
    if (byp_load) begin
        byp_data <= data_i;
    end
end

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
        byp_valid <= 1'b0;
    end else if (byp_load) begin
        byp_valid <= 1'b1;
    end else if (pop_i) begin
        byp_valid <= 1'b0;
    end
end

assign data_o = byp_valid ? byp_data : ram_q;

bram #(
    .MEM_WIDTH (FIFO_WIDTH ),
    .MEM_DEPTH (FIFO_DEPTH )
) i_bram (
    .clk_i     (clk_i      ),
    .wr_en_i   (ram_we     ),
    .wr_addr_i (wr_ptr     ),
    .wr_data_i (data_i     ),
    .rd_en_i   (ram_re     ),
    .rd_addr_i (rd_next_ptr),
    .rd_data_o (ram_q      )
);

if (CIRCLE_BUF == 1) begin : g_wrap_status
    logic wr_lap;
    logic rd_lap;
    logic same_ptr;

    // Lap bits flip each time a pointer wraps.
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            wr_lap <= 1'b0;
        end else if (push_i && wr_wrap) begin
            wr_lap <= ~wr_lap;
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            rd_lap <= 1'b0;
        end else if (pop_i && rd_wrap) begin
            rd_lap <= ~rd_lap;
        end
    end

    assign same_ptr = (wr_ptr == rd_ptr);
    assign full_o   = same_ptr & (wr_lap ^ rd_lap);
    assign empty_o  = same_ptr & ~(wr_lap ^ rd_lap);
end else begin : g_count_status
    logic [PTR_WIDTH:0] occupancy;

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            occupancy <= '0;
        end else begin
            case ({push_i, pop_i})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    assign full_o  = (occupancy == (PTR_WIDTH + 1)'(FIFO_DEPTH));
    assign empty_o = (occupancy == '0);
end

endmodule

// File: verilog/byte_packer.sv
`timescale 1ns/1ps

module byte_packer (
    input  logic                 clk_i,
    input  logic                 arstn_i,
    input  buf_types_pkg::byte_t in_byte_i,
    input  logic                 in_valid_i,
    input  logic                 fifo_full_i,
    output logic                 in_full_o,
    output logic                 fifo_push_o,
    output buf_types_pkg::word_t fifo_wdata_o
);

logic [buf_types_pkg::LANE_IDX_W-1:0] lane_idx;
buf_types_pkg::word_t                 hold_word;
logic                                 hold_valid;
logic                                 last_lane;
logic                                 accept;
// Lanes below the last one.
logic [(buf_types_pkg::BYTES_PER_WORD-1)*$bits(buf_types_pkg::byte_t)-1:0] lane_word;

assign last_lane = (int'(lane_idx) == buf_types_pkg::BYTES_PER_WORD - 1);

// Stall only when the next byte would complete a word with nowhere to go.
assign in_full_o = hold_valid & last_lane;
assign accept    = in_valid_i & ~in_full_o;

assign fifo_push_o  = hold_valid & ~fifo_full_i;
assign fifo_wdata_o = hold_word;

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
        lane_idx <= '0;
    end else if (accept) begin
        lane_idx <= lane_idx + 1'b1;   // Wraps after the last lane.
    end
end

always_ff @(posedge clk_i) begin
    if (accept && !last_lane) begin
        lane_word[int'(lane_idx)*$bits(buf_types_pkg::byte_t) +: $bits(buf_types_pkg::byte_t)]
            <= in_byte_i;
    end
end

// Final byte goes straight into the hold register with the earlier lanes.
always_ff @(posedge clk_i) begin
    if (accept && last_lane) begin
        hold_word <= {in_byte_i, lane_word};
    end
end

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
        hold_valid <= 1'b0;
    end else if (accept && last_lane) begin
        hold_valid <= 1'b1;
    end else if (fifo_push_o) begin
        hold_valid <= 1'b0;
    end
end

endmodule

// File: verilog/byte_unpacker.sv
`timescale 1ns/1ps

module byte_unpacker (
    input  logic                 clk_i,
    input  logic                 arstn_i,
    input  buf_types_pkg::word_t fifo_rdata_i,
    input  logic                 fifo_empty_i,
    input  logic                 out_pop_i,
    output logic                 fifo_pop_o,
    output buf_types_pkg::byte_t out_byte_o,
    output logic                 out_valid_o
);

buf_types_pkg::word_t                 word_q;
logic [buf_types_pkg::LANE_IDX_W-1:0] lane_idx;
logic                                 word_valid;
logic                                 last_lane;
logic                                 byte_pop;
logic                                 release_last;

assign last_lane    = (int'(lane_idx) == buf_types_pkg::BYTES_PER_WORD - 1);
assign byte_pop     = word_valid & out_pop_i;   // Pops without a byte are ignored.
assign release_last = byte_pop & last_lane;

// Refill when idle, or at the edge that releases the last lane.
assign fifo_pop_o = ~fifo_empty_i & (~word_valid | release_last);

always_ff @(posedge clk_i) begin
    if (fifo_pop_o) begin
        word_q <= fifo_rdata_i;
    end
end

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
        word_valid <= 1'b0;
        lane_idx   <= '0;
    end else if (fifo_pop_o) begin
        word_valid <= 1'b1;
        lane_idx   <= '0;   // Lane 0 is shown first.
    end else if (byte_pop) begin
        lane_idx <= lane_idx + 1'b1;
        if (last_lane) begin
            word_valid <= 1'b0;
        end
    end
end

assign out_valid_o = word_valid;

// Lane select.
assign out_byte_o =
    word_q[int'(lane_idx)*$bits(buf_types_pkg::byte_t) +: $bits(buf_types_pkg::byte_t)];

endmodule

// File: verilog/byte_buffer_top.sv
`timescale 1ns/1ps

module byte_buffer_top (
    input  logic                 clk_i,
    input  logic                 arstn_i,
    input  buf_types_pkg::byte_t in_byte_i,
    input  logic                 in_valid_i,
    input  logic                 out_pop_i,
    output logic                 in_full_o,
    output buf_types_pkg::byte_t out_byte_o,
    output logic                 out_valid_o
);

logic                 fifo_push;
buf_types_pkg::word_t fifo_wdata;
buf_types_pkg::word_t fifo_rdata;
logic                 fifo_full;
logic                 fifo_empty;
logic                 fifo_pop;

byte_packer i_byte_packer (
    .clk_i        (clk_i     ),
    .arstn_i      (arstn_i   ),
    .in_byte_i    (in_byte_i ),
    .in_valid_i   (in_valid_i),
    .fifo_full_i  (fifo_full ),
    .in_full_o    (in_full_o ),
    .fifo_push_o  (fifo_push ),
    .fifo_wdata_o (fifo_wdata)
);

// Word FIFO between the two byte domains.
sync_fifo #(
    .FIFO_WIDTH ($bits(buf_types_pkg::word_t)  ),
    .FIFO_DEPTH (buf_cfg_pkg::FIFO_DEPTH       ),
    .CIRCLE_BUF (buf_cfg_pkg::FIFO_STATUS_MODE )
) i_sync_fifo (
    .clk_i      (clk_i     ),
    .arstn_i    (arstn_i   ),
    .data_i     (fifo_wdata),
    .push_i     (fifo_push ),
    .pop_i      (fifo_pop  ),
    .data_o     (fifo_rdata),
    .full_o     (fifo_full ),
    .empty_o    (fifo_empty)
);

byte_unpacker i_byte_unpacker (
    .clk_i        (clk_i      ),
    .arstn_i      (arstn_i    ),
    .fifo_rdata_i (fifo_rdata ),
    .fifo_empty_i (fifo_empty ),
    .out_pop_i    (out_pop_i  ),
    .fifo_pop_o   (fifo_pop   ),
    .out_byte_o   (out_byte_o ),
    .out_valid_o  (out_valid_o)
);

endmodule

// File: verification/tb_byte_buffer.sv
`timescale 1ns/1ps

module tb_byte_buffer;

localparam int CLK_PERIOD    = 40;
localparam int RESET_CYCLES  = 8;
localparam int LANES         = buf_types_pkg::BYTES_PER_WORD;
localparam int VALID_LATENCY = 3;   // Counted up to the first cycle with out_valid_o high.
localparam int ORDER_BYTES   = 64;
localparam int FILL_CYCLES   = 100;
localparam int RANDOM_CYCLES = 1000;
localparam int DRAIN_LIMIT   = 200;
localparam int DRAIN_IDLE    = 4;
// Unpacker word, FIFO words and hold word, plus all lanes but the last.
localparam int FULL_BYTES    = (buf_cfg_pkg::FIFO_DEPTH + 2) * LANES + LANES - 1;
localparam int WATCHDOG_CYCLES = RESET_CYCLES + ORDER_BYTES + FILL_CYCLES + RANDOM_CYCLES
                               + 5 * DRAIN_LIMIT + 500;

logic                 clk_i;
logic                 arstn_i;
buf_types_pkg::byte_t in_byte_i;
logic                 in_valid_i;
logic                 out_pop_i;
logic                 in_full_o;
buf_types_pkg::byte_t out_byte_o;
logic                 out_valid_o;

buf_types_pkg::byte_t expect_q[$];   // Accepted bytes not yet popped.
buf_types_pkg::byte_t expected_byte;
logic [15:0]          lfsr_state;
int                   accepted_count;
int                   error_count;
int                   test_errors;
int                   test_num;
int                   pass_count;
int                   fail_count;

byte_buffer_top DUT (
    .clk_i       (clk_i      ),
    .arstn_i     (arstn_i    ),
    .in_byte_i   (in_byte_i  ),
    .in_valid_i  (in_valid_i ),
    .out_pop_i   (out_pop_i  ),
    .in_full_o   (in_full_o  ),
    .out_byte_o  (out_byte_o ),
    .out_valid_o (out_valid_o)
);

always #(CLK_PERIOD / 2) clk_i = ~clk_i;

// Scoreboard, sampled mid-cycle.
always @(negedge clk_i) begin
    if (arstn_i) begin
        if (out_valid_o && out_pop_i) begin
            assert (expect_q.size() > 0) else begin
                $display("Byte popped at %0t while the scoreboard was empty", $time);
                error_count++;
            end
            if (expect_q.size() > 0) begin
                expected_byte = expect_q.pop_front();
                assert (out_byte_o == expected_byte) else begin
                    $display("Error at %0t: out_byte_o expected 0x%02h, got 0x%02h",
                             $time, expected_byte, out_byte_o);
                    error_count++;
                end
            end
        end
        if (in_valid_i && !in_full_o) begin
            expect_q.push_back(in_byte_i);   // Taken at the next edge.
            accepted_count++;
        end
    end
end

// x^16 + x^14 + x^13 + x^11 + 1.
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
endfunction

task automatic take_bits(input int count, output buf_types_pkg::byte_t value);
    value = '0;
    for (int i = 0; i < count; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        value = {value[6:0], lfsr_state[0]};
    end
endtask

task automatic drive_cycle(input logic valid, input buf_types_pkg::byte_t data,
                           input logic pop);
    @(posedge clk_i);
    in_valid_i <= valid;
    in_byte_i  <= data;
    out_pop_i  <= pop;
endtask

// Returns at the edge that takes the last of the bytes.
task automatic send_bytes(input int count, input logic pop);
    int start;
    buf_types_pkg::byte_t data;
    start = accepted_count;
    while (1) begin
        @(posedge clk_i);
        if (accepted_count - start >= count) begin
            break;
        end
        take_bits(8, data);
        in_valid_i <= 1'b1;
        in_byte_i  <= data;
        out_pop_i  <= pop;
    end
    in_valid_i <= 1'b0;
    out_pop_i  <= 1'b0;
endtask

task automatic drain_output(output int popped);
    int idle;
    int cycles;
    idle   = 0;
    cycles = 0;
    popped = 0;
    while (idle < DRAIN_IDLE && cycles < DRAIN_LIMIT) begin
        drive_cycle(1'b0, 8'h00, 1'b1);
        @(negedge clk_i);
        if (out_valid_o) begin
            popped++;
            idle = 0;
        end else begin
            idle++;
        end
        cycles++;
    end
    drive_cycle(1'b0, 8'h00, 1'b0);
    assert (idle >= DRAIN_IDLE) else begin
        $display("Output was still streaming after %0d drain cycles", DRAIN_LIMIT);
        error_count++;
    end
endtask

task automatic start_test();
    test_errors = error_count;
endtask

task automatic finish_test(input string name);
    test_num++;
    if (error_count == test_errors) begin
        pass_count++;
        $display("Test %0d %s: passed", test_num, name);
    end else begin
        fail_count++;
        $display("Test %0d %s: failed with %0d errors", test_num, name,
                 error_count - test_errors);
    end
endtask

initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
end

initial begin
    int popped;
    int start;
    int edges;
    int full_cycles;
    buf_types_pkg::byte_t first_byte;
    buf_types_pkg::byte_t data;
    buf_types_pkg::byte_t coin_valid;
    buf_types_pkg::byte_t coin_pop;
    $timeformat(-9, 0, " ns", 0);
    clk_i          = 1'b0;
    arstn_i        = 1'b0;
    in_byte_i      = '0;
    in_valid_i     = 1'b0;
    out_pop_i      = 1'b0;
    lfsr_state     = 16'd67;
    accepted_count = 0;
    error_count    = 0;
    test_num       = 0;
    pass_count     = 0;
    fail_count     = 0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    arstn_i <= 1'b1;

    start_test();
    @(negedge clk_i);
    assert (!out_valid_o) else begin
        $display("Error at %0t: out_valid_o expected 0, got %0b", $time, out_valid_o);
        error_count++;
    end
    assert (!in_full_o) else begin
        $display("Error at %0t: in_full_o expected 0, got %0b", $time, in_full_o);
        error_count++;
    end
    finish_test("idle after reset");

    start_test();
    send_bytes(LANES, 1'b0);
    first_byte = expect_q[0];
    edges = 1;
    @(negedge clk_i);
    while (!out_valid_o && edges < DRAIN_LIMIT) begin
        @(negedge clk_i);
        edges++;
    end
    assert (edges == VALID_LATENCY) else begin
        $display("Error at %0t: out_valid_o latency expected %0d, got %0d",
                 $time, VALID_LATENCY, edges);
        error_count++;
    end
    assert (out_byte_o == first_byte) else begin
        $display("Error at %0t: out_byte_o expected 0x%02h, got 0x%02h",
                 $time, first_byte, out_byte_o);
        error_count++;
    end
    drain_output(popped);
    assert (popped == LANES) else begin
        $display("Error at %0t: popped bytes expected %0d, got %0d", $time, LANES, popped);
        error_count++;
    end
    finish_test("first word latency");

    start_test();
    send_bytes(ORDER_BYTES, 1'b1);
    drain_output(popped);
    assert (expect_q.size() == 0) else begin
        $display("Error at %0t: scoreboard depth expected 0, got %0d", $time, expect_q.size());
        error_count++;
    end
    finish_test("byte order");

    start_test();
    start       = accepted_count;
    full_cycles = 0;
    for (int i = 0; i < FILL_CYCLES; i++) begin
        take_bits(8, data);
        drive_cycle(1'b1, data, 1'b0);
        @(negedge clk_i);
        if (full_cycles > 0) begin
            assert (in_full_o) else begin
                $display("in_full_o dropped at %0t although nothing was popped", $time);
                error_count++;
            end
        end
        if (in_full_o) begin
            if (full_cycles == 0) begin
                assert (accepted_count - start == FULL_BYTES) else begin
                    $display("Error at %0t: accepted bytes expected %0d, got %0d",
                             $time, FULL_BYTES, accepted_count - start);
                    error_count++;
                end
            end
            full_cycles++;
        end
    end
    assert (full_cycles > 0) else begin
        $display("in_full_o never rose during %0d strobes", FILL_CYCLES);
        error_count++;
    end
    drive_cycle(1'b0, 8'h00, 1'b0);
    drain_output(popped);
    // Lane bytes stay put until their word is complete.
    assert (popped == FULL_BYTES - (LANES - 1)) else begin
        $display("Error at %0t: popped bytes expected %0d, got %0d",
                 $time, FULL_BYTES - (LANES - 1), popped);
        error_count++;
    end
    send_bytes(1, 1'b0);
    drain_output(popped);
    assert (popped == LANES) else begin
        $display("Error at %0t: popped bytes expected %0d, got %0d", $time, LANES, popped);
        error_count++;
    end
    assert (expect_q.size() == 0) else begin
        $display("Error at %0t: scoreboard depth expected 0, got %0d", $time, expect_q.size());
        error_count++;
    end
    finish_test("back-pressure");

    start_test();
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
        take_bits(1, coin_valid);
        take_bits(1, coin_pop);
        take_bits(8, data);
        drive_cycle(coin_valid[0], data, coin_pop[0]);
    end
    drive_cycle(1'b0, 8'h00, 1'b0);
    drain_output(popped);
    assert (expect_q.size() == accepted_count % LANES) else begin
        $display("Error at %0t: scoreboard depth expected %0d, got %0d",
                 $time, accepted_count % LANES, expect_q.size());
        error_count++;
    end
    finish_test("random traffic");

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && error_count == 0) begin
        $display("ALL TESTS PASSED");
    end else begin
        $display("SOME TESTS FAILED");
    end
    $finish;
end

endmodule

// File: compile.f
verilog/buf_types_pkg.sv
verilog/buf_cfg_pkg.sv
verilog/bram.sv
verilog/sync_fifo.sv
verilog/byte_packer.sv
verilog/byte_unpacker.sv
verilog/byte_buffer_top.sv
verification/tb_byte_buffer.sv

// File: Makefile
TOP = tb_byte_buffer

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f compile.f --top-module $(TOP)

# The pass message decides the status, not the exit code of the binary.
run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir
